//--- rtl/pmsi_pkg.sv
/* Shared widths, operation and PMSI state encodings,
   and the message structs for the pipeline, the L2 and write-backs */
package pmsi_pkg;

    localparam int ADDR_W = 16;  // Word address
    localparam int DATA_W = 32;

    // LD and ST come from the pipeline, the rest from the L2
    typedef enum logic [2:0] {
        NO_OP = 3'd0,
        LD    = 3'd1,
        ST    = 3'd2,
        RD    = 3'd3,
        WR    = 3'd4,
        INV   = 3'd5,
        UPD   = 3'd6,
        WR_LD = 3'd7
    } pmsi_op_e;

    // Bit 3 marks a pending state
    typedef enum logic [3:0] {
        I   = 4'd1,   // Invalid
        S   = 4'd2,   // Shared
        M   = 4'd4,   // Modified
        PS  = 4'd9,   // Pending Store
        PM  = 4'd10,  // Pending Modified
        PL  = 4'd11,  // Pending Load
        PLS = 4'd15   // Store arrived while the load was still pending
    } pmsi_state_e;

    // Pipeline request, op is LD or ST
    typedef struct packed {
        pmsi_op_e          op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } cpu_req_t;

    // Message from the L2
    typedef struct packed {
        pmsi_op_e          op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } l2_msg_t;

    // Miss or upgrade request towards the L2
    typedef struct packed {
        pmsi_op_e          op;
        logic [ADDR_W-1:0] addr;
    } l2_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } wb_t;

endpackage

//--- rtl/pmsi_next_state.sv
/* PMSI next-state table with evict priority and write-back decision */
module pmsi_next_state
    import pmsi_pkg::*;
(
    input  pmsi_op_e    operation,
    input  pmsi_state_e current_state,
    input  logic        is_evict,
    output pmsi_state_e next_state,
    output logic        wb_to_l2
);

    // Stable line thrown out, or dirty line snooped by the L2
    always_comb begin
        wb_to_l2 = (is_evict && !current_state[3]) ||
                   (current_state == M && operation == RD);
    end

    always_comb begin
        next_state = current_state;
        if (is_evict && (operation == LD || operation == ST)) begin
            // New tag takes over the line
            next_state = (operation == LD) ? PL : PS;
        end else begin
            case (current_state)
                I: begin
                    if (operation == LD) next_state = PL;  // Store to I is dropped
                end
                PL: begin
                    if (operation == WR || operation == WR_LD) next_state = S;
                    else if (operation == ST) next_state = PLS;
                    else if (operation == INV) next_state = I;
                end
                S: begin
                    if (operation == ST) next_state = PM;  // Upgrade
                    else if (operation == INV) next_state = I;
                end
                PLS: begin
                    if (operation == WR || operation == WR_LD) next_state = PM;
                    else if (operation == INV) next_state = I;
                end
                PM: begin
                    if (operation == UPD) next_state = M;
                    else if (operation == INV) next_state = I;
                end
                PS: begin
                    if (operation == WR || operation == WR_LD) next_state = M;
                    else if (operation == INV) next_state = I;
                end
                M: begin
                    if (operation == RD) next_state = S;
                    else if (operation == INV) next_state = I;
                end
                default: next_state = current_state;
            endcase
        end
    end

endmodule

//--- rtl/l1_tag_state_array.sv
/* Tag and coherence-state storage, one entry per direct-mapped line */
module l1_tag_state_array
    import pmsi_pkg::*;
#(
    parameter int INDEX_W = 4
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic [INDEX_W-1:0]        rd_index,
    output logic [ADDR_W-INDEX_W-1:0] tag,
    output pmsi_state_e               state,
    input  logic                      we,
    input  logic [INDEX_W-1:0]        wr_index,
    input  logic [ADDR_W-INDEX_W-1:0] wr_tag,
    input  pmsi_state_e               wr_state
);

    localparam int LINES = 1 << INDEX_W;
    localparam int TAG_W = ADDR_W - INDEX_W;

    logic [TAG_W-1:0] tag_q   [LINES];
    logic [3:0]       state_q [LINES];  // Raw code, checked below

    // Every line comes out of reset invalid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < LINES; i++) begin
                state_q[i] <= I;
            end
        end else if (we) begin
            state_q[wr_index] <= wr_state;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            tag_q[wr_index] <= wr_tag;
        end
    end

    // Combinational read
    assign tag   = tag_q[rd_index];
    assign state = pmsi_state_e'(state_q[rd_index]);

    // Every line must always hold a legal PMSI code
    for (genvar g = 0; g < LINES; g++) begin : g_state_chk
        a_state_legal: assert property (
            @(posedge clk) disable iff (!arst_n)
            state_q[g] inside {I, S, M, PS, PM, PL, PLS}
        ) else $error("line %0d holds illegal state %0h", g, state_q[g]);
    end

endmodule

//--- rtl/l1_data_array.sv
/* Data word and pending-store word per line */
module l1_data_array
    import pmsi_pkg::*;
#(
    parameter int INDEX_W = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [INDEX_W-1:0] index,
    output logic [DATA_W-1:0]  data,
    output logic [DATA_W-1:0]  pend,
    input  logic               data_we,
    input  logic [DATA_W-1:0]  data_in,
    input  logic               pend_we,
    input  logic [DATA_W-1:0]  pend_in
);

    localparam int LINES = 1 << INDEX_W;

    logic [DATA_W-1:0] data_q [LINES];
    logic [DATA_W-1:0] pend_q [LINES];  // Store data waiting for ownership

    // Both words start at zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < LINES; i++) begin
                data_q[i] <= '0;
                pend_q[i] <= '0;
            end
        end else begin
            if (data_we) begin
                data_q[index] <= data_in;
            end
            if (pend_we) begin
                pend_q[index] <= pend_in;
            end
        end
    end

    // Same index for read and write, read is combinational
    assign data = data_q[index];
    assign pend = pend_q[index];

endmodule

//--- rtl/l1_coherence_ctrl.sv
/* Operation select, eviction detection, array write control,
   and registered L2 requests, write-backs and load responses */
module l1_coherence_ctrl
    import pmsi_pkg::*;
#(
    parameter int INDEX_W = 4
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      cpu_valid,
    input  cpu_req_t                  cpu_req,
    input  logic                      l2_valid,
    input  l2_msg_t                   l2_msg,
    input  logic [ADDR_W-INDEX_W-1:0] line_tag,
    input  pmsi_state_e               line_state,
    input  logic [DATA_W-1:0]         line_data,
    input  logic [DATA_W-1:0]         line_pend,
    input  pmsi_state_e               next_state,
    input  logic                      wb_to_l2,
    output pmsi_op_e                  operation,
    output pmsi_state_e               current_state,
    output logic                      is_evict,
    output logic [INDEX_W-1:0]        line_index,
    output logic                      tag_we,
    output logic [ADDR_W-INDEX_W-1:0] wr_tag,
    output pmsi_state_e               wr_state,
    output logic                      data_we,
    output logic [DATA_W-1:0]         data_in,
    output logic                      pend_we,
    output logic [DATA_W-1:0]         pend_in,
    output logic                      l2_req_valid,
    output l2_req_t                   l2_req,
    output logic                      wb_valid,
    output wb_t                       wb,
    output logic                      ld_valid,
    output logic [DATA_W-1:0]         ld_data
);

    logic [ADDR_W-1:0]        req_addr;
    logic [ADDR_W-INDEX_W-1:0] req_tag;
    logic                     tag_hit;
    logic                     is_fill;
    logic                     enter;   // Line changes state or owner
    logic                     req_ld;
    logic                     req_st;
    logic                     ld_hit;
    logic                     ld_fill;

    assign req_addr   = cpu_valid ? cpu_req.addr : l2_msg.addr;
    assign line_index = req_addr[INDEX_W-1:0];
    assign req_tag    = req_addr[ADDR_W-1:INDEX_W];
    assign tag_hit    = (req_tag == line_tag);

    // L2 messages for another tag are dropped
    always_comb begin
        if (cpu_valid) operation = cpu_req.op;
        else if (l2_valid && tag_hit) operation = l2_msg.op;
        else operation = NO_OP;
    end

    assign current_state = line_state;
    assign is_evict      = cpu_valid && !tag_hit && (line_state != I);

    // Array updates
    assign tag_we   = (operation != NO_OP);
    assign wr_tag   = req_tag;
    assign wr_state = next_state;
    assign is_fill  = (operation == WR) || (operation == WR_LD);

    assign data_we = is_fill || (operation == UPD) ||
                     (operation == ST && !is_evict && line_state == M);
    always_comb begin
        if (is_fill) begin
            // Waiting store wins over the fill
            data_in = (line_state inside {PS, PLS}) ? line_pend : l2_msg.data;
        end else if (operation == UPD) begin
            data_in = line_pend;
        end else begin
            data_in = cpu_req.wdata;
        end
    end

    assign pend_we = (operation == ST) && (next_state inside {PS, PM, PLS});
    assign pend_in = cpu_req.wdata;

    // Outgoing requests and load responses
    assign enter   = is_evict || (next_state != line_state);
    assign req_ld  = enter && (next_state == PL);
    assign req_st  = enter && ((next_state inside {PS, PLS}) ||
                               (line_state == S && next_state == PM));
    assign ld_hit  = (operation == LD) && tag_hit && (line_state inside {S, M, PM});
    assign ld_fill = is_fill && (line_state inside {PL, PLS});

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            l2_req_valid <= 1'b0;
            l2_req       <= '0;
            wb_valid     <= 1'b0;
            wb           <= '0;
            ld_valid     <= 1'b0;
            ld_data      <= '0;
        end else begin
            l2_req_valid <= req_ld || req_st;
            wb_valid     <= wb_to_l2;
            ld_valid     <= ld_hit || ld_fill;
            if (req_ld || req_st) begin
                l2_req.op   <= req_ld ? LD : ST;
                l2_req.addr <= req_addr;
            end
            if (wb_to_l2) begin
                wb.addr <= {line_tag, line_index};  // Old owner of the line
                wb.data <= line_data;
            end
            if (ld_hit || ld_fill) begin
                ld_data <= ld_fill ? l2_msg.data : line_data;
            end
        end
    end

    a_one_source: assert property (
        @(posedge clk) disable iff (!arst_n) !(cpu_valid && l2_valid)
    ) else $error("pipeline and L2 strobed in the same cycle");

    // A stable victim must be written back on the next cycle
    a_evict_wb: assert property (
        @(posedge clk) disable iff (!arst_n)
        (is_evict && !line_state[3]) |=> wb_valid
    ) else $error("evicted stable line without write-back");

endmodule

//--- rtl/l1_coherent_cache.sv
/* Direct-mapped coherent L1, tag/state and data arrays around the PMSI controller */
module l1_coherent_cache
    import pmsi_pkg::*;
#(
    parameter int INDEX_W = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cpu_valid,
    input  cpu_req_t          cpu_req,
    input  logic              l2_valid,
    input  l2_msg_t           l2_msg,
    output logic              l2_req_valid,
    output l2_req_t           l2_req,
    output logic              wb_valid,
    output wb_t               wb,
    output logic              ld_valid,
    output logic [DATA_W-1:0] ld_data
);

    localparam int TAG_W = ADDR_W - INDEX_W;

    logic [INDEX_W-1:0] line_index;
    logic [TAG_W-1:0]   line_tag, wr_tag;
    pmsi_state_e        line_state, current_state, next_state, wr_state;
    logic [DATA_W-1:0]  line_data, line_pend, data_in, pend_in;
    logic               tag_we, data_we, pend_we;
    pmsi_op_e           operation;
    logic               is_evict, wb_to_l2;

    l1_tag_state_array #(.INDEX_W(INDEX_W)) u_tags (
        .clk, .arst_n,
        .rd_index (line_index),
        .tag      (line_tag),
        .state    (line_state),
        .we       (tag_we),
        .wr_index (line_index),  // Read and write hit the same line
        .wr_tag, .wr_state
    );

    l1_data_array #(.INDEX_W(INDEX_W)) u_data (
        .clk, .arst_n,
        .index (line_index),
        .data  (line_data),
        .pend  (line_pend),
        .data_we, .data_in, .pend_we, .pend_in
    );

    l1_coherence_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (.*);

    pmsi_next_state u_fsm (
        .operation, .current_state, .is_evict, .next_state, .wb_to_l2
    );

endmodule

//--- tb/tb_pmsi_model.svh
/* Line model of the PMSI cache, next-state table and the function
   that predicts the registered outputs for one strobe */
`ifndef TB_PMSI_MODEL_SVH
`define TB_PMSI_MODEL_SVH

typedef struct packed {
    logic              l2_req_valid;
    l2_req_t           l2_req;
    logic              wb_valid;
    wb_t               wb;
    logic              ld_valid;
    logic [DATA_W-1:0] ld_data;
} expect_t;

logic [TAG_W-1:0]  m_tag   [LINES];
pmsi_state_e       m_state [LINES];
logic [DATA_W-1:0] m_data  [LINES];
logic [DATA_W-1:0] m_pend  [LINES];  // Store word waiting for ownership

function automatic pmsi_state_e model_next_state(pmsi_op_e op, pmsi_state_e st, logic evict);
    if (evict) begin
        return (op == LD) ? PL : PS;  // New owner takes the line
    end
    if (op == INV) begin
        return I;
    end
    case (op)
        LD: return (st == I) ? PL : st;
        ST: begin
            if (st == S) return PM;
            if (st == PL) return PLS;
        end
        WR, WR_LD: begin
            if (st == PL) return S;
            if (st == PLS) return PM;
            if (st == PS) return M;
        end
        UPD: if (st == PM) return M;
        RD: if (st == M) return S;
        default: ;
    endcase
    return st;
endfunction

function automatic expect_t predict_outputs(logic from_cpu, pmsi_op_e op,
                                            logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] wdata);
    expect_t            e;
    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   tg;
    pmsi_state_e        st;
    pmsi_state_e        ns;
    logic               match;
    logic               evict;
    e     = '0;
    idx   = addr[INDEX_W-1:0];
    tg    = addr[ADDR_W-1:INDEX_W];
    st    = m_state[idx];
    match = (tg == m_tag[idx]);
    evict = from_cpu && !match && (st != I);
    if (!from_cpu && !match) begin
        return e;  // L2 message for another tag
    end
    ns = model_next_state(op, st, evict);

    // Outputs use the line before the update
    if ((evict && !st[3]) || (st == M && op == RD)) begin
        e.wb_valid = 1'b1;
        e.wb.addr  = {m_tag[idx], idx};
        e.wb.data  = m_data[idx];
    end
    if (evict || ns != st) begin
        e.l2_req.addr = addr;
        if (ns == PL) begin
            e.l2_req_valid = 1'b1;
            e.l2_req.op    = LD;
        end else if ((ns inside {PS, PLS}) || (st == S && ns == PM)) begin
            e.l2_req_valid = 1'b1;
            e.l2_req.op    = ST;
        end
    end
    if (op == LD && match && (st inside {S, M, PM})) begin
        e.ld_valid = 1'b1;
        e.ld_data  = m_data[idx];
    end else if ((op == WR || op == WR_LD) && (st inside {PL, PLS})) begin
        e.ld_valid = 1'b1;
        e.ld_data  = wdata;  // Fill data goes straight to the pipeline
    end

    if (op == WR || op == WR_LD) begin
        m_data[idx] = (st inside {PS, PLS}) ? m_pend[idx] : wdata;
    end else if (op == UPD) begin
        m_data[idx] = m_pend[idx];
    end else if (op == ST && !evict && st == M) begin
        m_data[idx] = wdata;
    end
    if (op == ST && (ns inside {PS, PM, PLS})) begin
        m_pend[idx] = wdata;
    end
    m_tag[idx]   = tg;
    m_state[idx] = ns;
    return e;
endfunction

`endif

//--- tb/tb_l1_coherent_cache.sv
/* Testbench for the coherent L1, directed PMSI scenarios and a random
   pipeline/L2 mix compared every cycle with the line model */
module tb_l1_coherent_cache
    import pmsi_pkg::*;
();

    localparam int INDEX_W    = 2;
    localparam int LINES      = 1 << INDEX_W;
    localparam int TAG_W      = ADDR_W - INDEX_W;
    localparam int N_RANDOM   = 2000;
    localparam int MAX_CYCLES = N_RANDOM + 1000;  // Random mix, idles, directed part, reset

    `include "tb_pmsi_model.svh"

    logic              clk;
    logic              arst_n;
    logic              cpu_valid;
    cpu_req_t          cpu_req;
    logic              l2_valid;
    l2_msg_t           l2_msg;
    logic              l2_req_valid;
    l2_req_t           l2_req;
    logic              wb_valid;
    wb_t               wb;
    logic              ld_valid;
    logic [DATA_W-1:0] ld_data;

    logic [TAG_W-1:0] tags [4];  // Few tags so lines get evicted often
    expect_t          exp_next;
    expect_t          exp_cur;
    int               errors;
    int               checks;
    int               cycles;

    l1_coherent_cache #(.INDEX_W(INDEX_W)) dut0 (.*);

    always #20 clk = ~clk;

    function automatic logic [ADDR_W-1:0] line_addr(int t, int i);
        return {tags[2'(t)], INDEX_W'(i)};
    endfunction

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    task automatic drive(input logic from_cpu, input pmsi_op_e op,
                         input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge clk);
        #5;
        cpu_valid = from_cpu;
        l2_valid  = !from_cpu;
        if (from_cpu) begin
            cpu_req = '{op: op, addr: addr, wdata: data};
        end else begin
            l2_msg = '{op: op, addr: addr, data: data};
        end
        exp_next = predict_outputs(from_cpu, op, addr, data);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #5;
        cpu_valid = 1'b0;
        l2_valid  = 1'b0;
        exp_next  = '0;
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("FAIL %s got %0h expected %0h", name, got, want);
        end
    endtask

    // Expectation of the strobe captured at this edge
    always @(posedge clk) exp_cur <= exp_next;

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (arst_n) begin
            check_value("l2_req_valid", 64'(l2_req_valid), 64'(exp_cur.l2_req_valid));
            if (exp_cur.l2_req_valid) check_value("l2_req", 64'(l2_req), 64'(exp_cur.l2_req));
            check_value("wb_valid", 64'(wb_valid), 64'(exp_cur.wb_valid));
            if (exp_cur.wb_valid) check_value("wb", 64'(wb), 64'(exp_cur.wb));
            check_value("ld_valid", 64'(ld_valid), 64'(exp_cur.ld_valid));
            if (exp_cur.ld_valid) check_value("ld_data", 64'(ld_data), 64'(exp_cur.ld_data));
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            errors++;
            $display("Timeout, run did not finish within %0d cycles", MAX_CYCLES);
            finish_run();
        end
    end

    initial begin
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tg;
        pmsi_op_e           op;
        void'($urandom(32'h75df_2dea));
        clk       = 1'b0;
        arst_n    = 1'b0;
        cpu_valid = 1'b0;
        cpu_req   = '0;
        l2_valid  = 1'b0;
        l2_msg    = '0;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        exp_next  = '0;
        exp_cur   = '0;
        tags      = '{14'h0001, 14'h0a5c, 14'h1f30, 14'h3e07};
        m_tag     = '{default: '0};
        m_state   = '{default: I};
        m_data    = '{default: '0};
        m_pend    = '{default: '0};
        repeat (8) @(posedge clk);
        #5 arst_n = 1'b1;

        for (int i = 0; i < LINES; i++) begin
            drive(1'b1, LD, line_addr(0, i), '0);  // Cold miss on each line
        end
        drive(1'b0, WR_LD, line_addr(0, 0), 32'h1111_0000);
        drive(1'b1, LD, line_addr(0, 0), '0);
        drive(1'b1, ST, line_addr(0, 0), 32'h2222_0001);  // Upgrade from S
        drive(1'b0, UPD, line_addr(0, 0), '0);
        drive(1'b1, LD, line_addr(0, 0), '0);
        // Store lands while the load is still pending
        drive(1'b1, ST, line_addr(0, 1), 32'h3333_0002);
        drive(1'b0, WR, line_addr(0, 1), 32'h4444_0003);
        drive(1'b1, LD, line_addr(0, 1), '0);
        drive(1'b0, UPD, line_addr(0, 1), '0);
        drive(1'b1, LD, line_addr(0, 1), '0);
        drive(1'b1, LD, line_addr(1, 0), '0);  // Evicts a dirty line
        drive(1'b0, WR_LD, line_addr(1, 0), 32'h5555_0004);
        drive(1'b0, RD, line_addr(0, 1), '0);
        drive(1'b1, ST, line_addr(2, 1), 32'h6666_0005);  // Evicts a shared line
        drive(1'b0, WR, line_addr(2, 1), 32'h7777_0006);
        drive(1'b0, INV, line_addr(2, 1), '0);
        idle_cycle();
        drive(1'b1, LD, line_addr(2, 1), '0);

        for (int n = 0; n < N_RANDOM; n++) begin
            if ($urandom_range(7) == 0) idle_cycle();
            idx = INDEX_W'($urandom_range(LINES - 1));
            if (n % 2 == 0) begin
                op = ($urandom_range(1) == 0) ? LD : ST;
                drive(1'b1, op, {tags[2'($urandom_range(3))], idx}, $urandom);
            end else begin
                // Mostly the resident tag, so the message applies
                tg = ($urandom_range(3) == 0) ? tags[2'($urandom_range(3))] : m_tag[idx];
                op = pmsi_op_e'(3'($urandom_range(7, 3)));
                drive(1'b0, op, {tg, idx}, $urandom);
            end
        end
        idle_cycle();
        idle_cycle();
        finish_run();
    end

endmodule

//--- verilog.f
+incdir+tb
rtl/pmsi_pkg.sv
rtl/pmsi_next_state.sv
rtl/l1_tag_state_array.sv
rtl/l1_data_array.sv
rtl/l1_coherence_ctrl.sv
rtl/l1_coherent_cache.sv
tb/tb_l1_coherent_cache.sv

//--- Makefile
# Verilator flow for the coherent L1 testbench

VERILATOR ?= verilator
TOP       ?= tb_l1_coherent_cache
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test FAILED
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
